// ==== project.f ====
+incdir+verilog
verilog/msx_pkg.sv
verilog/load_pkg.sv
verilog/upload_tracker.sv
verilog/load_sequencer.sv
verilog/fill_pattern.sv
verilog/slot_table.sv
verilog/memory_upload.sv
tests/ddr_model.sv
tests/tb_memory_upload.sv

// ==== Makefile ====
# Verilator build and run of the machine image loader testbench
SIM  := obj_dir/Vtb_memory_upload
SRCS := $(filter-out +incdir+%,$(shell cat project.f)) verilog/loader_params.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): project.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_memory_upload -f project.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== tests/tb_memory_upload.sv ====
//########################################
// Loader testbench. Builds an MSX image in
// the DDR model, runs two downloads and a
// reload, then checks RAM and the tables.
//########################################
`include "loader_params.svh"

module tb_memory_upload;
    timeunit 1ns;
    timeprecision 1ps;
    import msx_pkg::*;
    import load_pkg::*;

    localparam int IMG_MAX = 32768;
    localparam int RAM_MAX = 131072;
    localparam int UNIT    = 1 << `LD_BLOCK_SHIFT;
    // Nine 16 KB units filled over three loads, plus clear and record overhead
    localparam int TIMEOUT = 4 * 9 * UNIT + 3 * (`LD_SLOT_BLOCKS + 5 * 8 * `LD_REC_BYTES) + 1000;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         ioctl_download;
    logic [15:0]  ioctl_index;
    img_size_t    ioctl_addr;
    logic         reload;
    ddr_addr_t    ddr3_addr;
    logic         ddr3_rd;
    logic [7:0]   ddr3_dout;
    logic         ddr3_ready;
    logic         ddr3_request;
    ram_wr_t      ram;
    logic         sdram_ready;
    slot_block_t  slot_layout [`LD_SLOT_BLOCKS];
    ram_lookup_t  ram_lookup [`LD_RAM_REFS];
    bios_config_t bios_config;
    logic         reset_rq;
    logic         load_done;

    logic [7:0]   img [IMG_MAX];
    int           img_len;
    logic [7:0]   exp_ram [RAM_MAX];
    int           exp_len;
    ram_lookup_t  exp_lookup [`LD_RAM_REFS];
    slot_block_t  exp_layout [`LD_SLOT_BLOCKS];
    bios_config_t exp_bios;
    int           writes_base;
    int           loads_checked = 0;
    int           cycles = 0;
    logic         rq_prev = 1'b0;

    memory_upload dut (.*);

    ddr_model mem_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .ddr3_addr   (ddr3_addr),
        .ddr3_rd     (ddr3_rd),
        .ddr3_dout   (ddr3_dout),
        .ddr3_ready  (ddr3_ready),
        .ram         (ram),
        .sdram_ready (sdram_ready)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic mismatch(input string what, input logic [63:0] got, input logic [63:0] exp);
        stop_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) stop_run($sformatf("Timeout: loads not done in %0d cycles", TIMEOUT));
    end

    task automatic put_record(input int base, input logic [7:0] type_slot, input logic [7:0] id,
                              input logic [7:0] size, input logic [7:0] mapper,
                              input logic [7:0] mode, input logic [7:0] param,
                              input logic [7:0] pattern);
        for (int i = 0; i < `LD_REC_BYTES; i++) img[base + i] = 8'h00;
        img[base + 0]                = `LD_SIG0;
        img[base + 1]                = `LD_SIG1;
        img[base + 2]                = `LD_SIG2;
        img[base + `LD_REC_TYPE]     = type_slot;   // Type high nibble, slot/subslot low
        img[base + `LD_REC_ID]       = id;
        img[base + `LD_REC_SIZE_LO]  = size;
        img[base + `LD_REC_MAPPER]   = mapper;
        img[base + `LD_REC_MODE]     = mode;
        img[base + `LD_REC_PARAM]    = param;
        img[base + `LD_REC_PATTERN]  = pattern;
    endtask

    task automatic build_image(input logic bad_third);
        put_record(0, 8'h44, DATA_ROM, 8'd1, 8'h03, 8'h0A, 8'h04, 8'd0);
        for (int i = 0; i < UNIT; i++) img[16 + i] = 8'((i * 7) ^ (i >> 8));
        put_record(16 + UNIT, 8'h4C, DATA_RAM, 8'd1, 8'h00, 8'h0E, 8'h04, 8'd1);
        put_record(32 + UNIT, 8'h4C, DATA_RAM, 8'd2, 8'h01, 8'h90, 8'h40, 8'd3);
        put_record(48 + UNIT, 8'h4D, DATA_RAM, 8'd1, 8'h02, 8'h02, 8'h00, 8'd5);
        put_record(64 + UNIT, 8'h60, 8'h2A, 8'd0, 8'h00, 8'h00, 8'h00, 8'd0);
        if (bad_third) img[32 + UNIT] = 8'h6D;   // Lower case m
        img_len = 80 + UNIT;
        for (int i = 0; i < img_len; i++) mem_model.ddr_mem[i] = img[i];
    endtask

    // Expected test pattern byte at offset k inside a region
    function automatic logic [7:0] pattern_byte(input logic [2:0] sel, input int k);
        int   pos;
        logic on;
        pos = k % 512;                         // Offset counter wraps every 512 bytes
        case (sel)
            3'd2:    on = 1'b0;
            3'd3:    on = ((pos % 4) < 2) ^ (pos >= 256);
            3'd4:    on = ((pos % 2) == 1) ^ (pos >= 256);
            3'd5:    on = (pos % 256) >= 128;
            default: on = 1'b1;
        endcase
        return on ? 8'hFF : 8'h00;
    endfunction

    // Reference model of a whole load over the image
    function automatic void compute_expected();
        slot_block_t old [`LD_SLOT_BLOCKS];
        logic [7:0]  r [`LD_REC_BYTES];
        int          pos;
        int          ref_idx;
        int          nbytes;
        int          blk;
        int          sib;
        logic [1:0]  mode;
        logic [1:0]  param;
        logic        is_rom;
        ram_ref_t    ref_val;
        pos      = 0;
        ref_idx  = 0;
        exp_len  = 0;
        exp_bios = '0;
        for (int i = 0; i < `LD_RAM_REFS; i++) exp_lookup[i] = '0;
        for (int i = 0; i < `LD_SLOT_BLOCKS; i++) begin
            exp_layout[i] = '{MAPPER_UNUSED, DEVICE_NONE, 4'd0, 2'd0, 1'b0};
        end
        while (pos < img_len) begin
            for (int i = 0; i < `LD_REC_BYTES; i++) r[i] = img[pos + i];
            if (r[0] != `LD_SIG0 || r[1] != `LD_SIG1 || r[2] != `LD_SIG2) break;
            pos += `LD_REC_BYTES;
            if (rec_type_t'(r[3][7:4]) == REC_CONFIG) begin
                exp_bios.slot_expander_en = r[4][3:0];
                exp_bios.msx_typ          = msx_typ_t'(r[4][5:4]);
            end else if (rec_type_t'(r[3][7:4]) == REC_SLOT_INTERNAL) begin
                is_rom  = r[4] != DATA_RAM;
                nbytes  = int'({r[5], r[6]}) * UNIT;
                ref_val = (r[4] == DATA_NONE) ? 4'd0 : ram_ref_t'(ref_idx);
                if (r[4] == 8'h03) exp_bios.use_fdc = 1'b1;
                if (!is_rom && r[6] > exp_bios.ram_size) exp_bios.ram_size = r[6];
                if (nbytes != 0) begin
                    exp_lookup[ref_idx] = '{27'(exp_len), {r[5], r[6]}, is_rom};
                    for (int k = 0; k < nbytes; k++) begin
                        exp_ram[exp_len + k] = is_rom ? img[pos + k] : pattern_byte(r[11][2:0], k);
                    end
                    if (is_rom) pos += nbytes;       // ROM data follows its record
                    exp_len += nbytes;
                end
                old = exp_layout;
                for (int b = 0; b < 4; b++) begin
                    mode  = r[9][2*b +: 2];
                    param = r[10][2*b +: 2];
                    blk   = int'(r[3][3:0]) * 4 + b;
                    sib   = int'(r[3][3:0]) * 4 + int'(param);
                    case (mode)
                        2'd1: exp_layout[blk] = '{old[sib].mapper, DEVICE_NONE, old[sib].ref_ram,
                                                  old[sib].offset_ram, 1'b0};
                        2'd2: exp_layout[blk] = '{mapper_t'(r[8]), mem_device_t'(r[4]), ref_val,
                                                  param, 1'b0};
                        2'd3: exp_layout[blk] = '{MAPPER_UNUSED, mem_device_t'(r[4]), ref_val,
                                                  param, 1'b0};
                        default: ;
                    endcase
                end
                if (nbytes != 0) ref_idx++;
            end
        end
    endfunction

    task automatic check_outputs();
        int writes;
        writes = mem_model.ram_writes - writes_base;
        assert (writes == exp_len) else mismatch("RAM write count", 64'(writes), 64'(exp_len));
        for (int a = 0; a < exp_len; a++) begin
            assert (mem_model.ram_mem[a] === exp_ram[a])
                else mismatch($sformatf("RAM byte %0d", a), 64'(mem_model.ram_mem[a]),
                              64'(exp_ram[a]));
        end
        for (int i = 0; i < `LD_RAM_REFS; i++) begin
            assert (ram_lookup[i] === exp_lookup[i])
                else mismatch($sformatf("lookup entry %0d", i), 64'(ram_lookup[i]),
                              64'(exp_lookup[i]));
        end
        for (int i = 0; i < `LD_SLOT_BLOCKS; i++) begin
            assert (slot_layout[i] === exp_layout[i])
                else mismatch($sformatf("layout entry %0d", i), 64'(slot_layout[i]),
                              64'(exp_layout[i]));
        end
        assert (bios_config === exp_bios)
            else mismatch("bios_config", 64'(bios_config), 64'(exp_bios));
    endtask

    always @(negedge clk) begin
        if (rst_n && load_done) begin
            assert (rq_prev && !reset_rq) else stop_run("reset_rq did not fall with load_done");
            assert (!ddr3_request) else stop_run("ddr3_request still high after load_done");
            check_outputs();
            loads_checked <= loads_checked + 1;
        end
        rq_prev <= reset_rq;
    end

    task automatic start_load(input logic use_reload);
        compute_expected();
        writes_base = mem_model.ram_writes;
        for (int a = 0; a < RAM_MAX; a++) begin
            mem_model.ram_mem[a] = 8'(a ^ (a >> 8) ^ (a >> 16));   // Stale data marker
        end
        @(posedge clk);
        if (use_reload) begin
            reload <= 1'b1;
        end else begin
            ioctl_index    <= 16'(`LD_IMG_INDEX);
            ioctl_addr     <= img_size_t'(img_len);
            ioctl_download <= 1'b1;
            repeat (4) @(posedge clk);
            ioctl_download <= 1'b0;            // Falling edge ends the download
        end
        @(posedge clk);
        reload <= 1'b0;
        @(negedge clk);
        assert (!reset_rq) else stop_run("reset_rq rose before load_start");
        @(negedge clk);
        assert (reset_rq) else stop_run("reset_rq did not rise after load_start");
        assert (ddr3_request) else stop_run("ddr3_request not raised for the load");
    endtask

    initial begin
        void'($urandom(32'h66f4));
        rst_n          = 1'b0;
        ioctl_download = 1'b0;
        ioctl_index    = 16'd0;
        ioctl_addr     = '0;
        reload         = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!reset_rq && !ddr3_rd && !ram.ce && !load_done && !ddr3_request)
            else stop_run("outputs not low after reset");
        build_image(1'b0);
        start_load(1'b0);
        wait (loads_checked == 1);
        build_image(1'b1);
        start_load(1'b0);
        wait (loads_checked == 2);
        start_load(1'b1);                      // Same image again
        wait (loads_checked == 3);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tests/ddr_model.sv ====
//########################################
// DDR and RAM stand-ins for the loader
// testbench. DDR bytes come from an array
// with random stalls, RAM writes are kept.
//########################################
`include "loader_params.svh"

module ddr_model (
    input  logic                clk,
    input  logic                rst_n,
    input  load_pkg::ddr_addr_t ddr3_addr,
    input  logic                ddr3_rd,
    output logic [7:0]          ddr3_dout,
    output logic                ddr3_ready,
    input  load_pkg::ram_wr_t   ram,
    output logic                sdram_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] ddr_mem [32768];     // Image, written by the testbench
    logic [7:0] ram_mem [131072];
    int         ram_writes;

    initial begin
        ddr3_dout   <= 8'h00;
        ddr3_ready  <= 1'b0;
        sdram_ready <= 1'b0;
        ram_writes  <= 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ddr3_ready  <= 1'b0;
            sdram_ready <= 1'b0;
        end else begin
            ddr3_ready  <= ($urandom % 4) != 0;   // Stall one cycle in four
            sdram_ready <= ($urandom % 8) != 0;
        end
        if (ddr3_rd && ddr3_ready) ddr3_dout <= ddr_mem[ddr3_addr[14:0]];
        if (ram.ce) begin
            ram_mem[ram.addr[16:0]] <= ram.din;
            ram_writes <= ram_writes + 1;
        end
    end

endmodule

// ==== verilog/memory_upload.sv ====
//########################################
// Machine image loader top. Starts on an
// image download or reload, holds the core
// in reset while RAM and tables are built.
//########################################
`include "loader_params.svh"

module memory_upload (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ioctl_download,
    input  logic [15:0]           ioctl_index,
    input  load_pkg::img_size_t   ioctl_addr,
    input  logic                  reload,
    output load_pkg::ddr_addr_t   ddr3_addr,
    output logic                  ddr3_rd,
    input  logic [7:0]            ddr3_dout,
    input  logic                  ddr3_ready,
    output logic                  ddr3_request,
    output load_pkg::ram_wr_t     ram,
    input  logic                  sdram_ready,
    output msx_pkg::slot_block_t  slot_layout [`LD_SLOT_BLOCKS],
    output msx_pkg::ram_lookup_t  ram_lookup [`LD_RAM_REFS],
    output msx_pkg::bios_config_t bios_config,
    output logic                  reset_rq,
    output logic                  load_done
);
    import load_pkg::*;

    img_size_t    img_size;
    logic         load_start;
    logic         ram_ce;
    ram_addr_t    ram_addr;
    logic [7:0]   din;
    logic [2:0]   pattern_sel;
    logic         region_start;
    logic         table_clear;
    logic [5:0]   clear_index;
    block_store_t block_store;

    assign ram = '{addr: ram_addr, din: din, ce: ram_ce};

    upload_tracker u_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_addr     (ioctl_addr),
        .reload         (reload),
        .img_size       (img_size),
        .load_start     (load_start)
    );

    load_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_start   (load_start),
        .img_size     (img_size),
        .ddr3_dout    (ddr3_dout),
        .ddr3_ready   (ddr3_ready),
        .sdram_ready  (sdram_ready),
        .ddr3_addr    (ddr3_addr),
        .ddr3_rd      (ddr3_rd),
        .ddr3_request (ddr3_request),
        .reset_rq     (reset_rq),
        .load_done    (load_done),
        .ram_ce       (ram_ce),
        .ram_addr     (ram_addr),
        .pattern_sel  (pattern_sel),
        .region_start (region_start),
        .table_clear  (table_clear),
        .clear_index  (clear_index),
        .block_store  (block_store),
        .ram_lookup   (ram_lookup),
        .bios_config  (bios_config)
    );

    fill_pattern u_pattern (
        .clk          (clk),
        .rst_n        (rst_n),
        .pattern_sel  (pattern_sel),
        .region_start (region_start),
        .ram_ce       (ram_ce),
        .ddr3_dout    (ddr3_dout),
        .din          (din)
    );

    slot_table u_slots (
        .clk         (clk),
        .rst_n       (rst_n),
        .table_clear (table_clear),
        .clear_index (clear_index),
        .block_store (block_store),
        .slot_layout (slot_layout)
    );

endmodule

// ==== verilog/slot_table.sv ====
//########################################
// Slot layout table, 4 slots x 4 subslots
// x 4 blocks. Cleared entry by entry at a
// load, then written by block stores.
//########################################
`include "loader_params.svh"

module slot_table (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   table_clear,
    input  logic [5:0]             clear_index,
    input  load_pkg::block_store_t block_store,
    output msx_pkg::slot_block_t   slot_layout [`LD_SLOT_BLOCKS]
);
    import msx_pkg::*;
    import load_pkg::*;

    function automatic slot_block_t new_block(
        input logic [1:0]   mode,
        input logic [1:0]   param,
        input slot_block_t  sibling,
        input block_store_t st
    );
        slot_block_t blk;
        blk.mapper     = st.mapper;
        blk.device     = st.device;
        blk.ref_ram    = (st.data_id == DATA_NONE) ? '0 : st.ref_ram;
        blk.offset_ram = param;
        blk.external   = 1'b0;
        case (mode)
            2'd1: begin                      // Mirror of another block
                blk.mapper     = sibling.mapper;
                blk.device     = DEVICE_NONE;
                blk.ref_ram    = sibling.ref_ram;
                blk.offset_ram = sibling.offset_ram;
            end
            2'd3:    blk.mapper = MAPPER_UNUSED;   // Device only
            default: ;
        endcase
        return blk;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n) begin
            if (table_clear) begin
                slot_layout[clear_index] <= '{MAPPER_UNUSED, DEVICE_NONE, '0, '0, 1'b0};
            end
            if (block_store.stb) begin
                for (int i = 0; i < 4; i++) begin
                    if (block_store.mode[2*i +: 2] != 2'd0) begin
                        slot_layout[{block_store.slot_sel, 2'(i)}] <= new_block(
                            block_store.mode[2*i +: 2],
                            block_store.param[2*i +: 2],
                            slot_layout[{block_store.slot_sel, block_store.param[2*i +: 2]}],
                            block_store);
                    end
                end
            end
        end
    end

endmodule

// ==== verilog/fill_pattern.sv ====
//########################################
// RAM write data source. Passes the DDR
// byte or builds a test pattern from the
// write offset inside the current region.
//########################################

module fill_pattern (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] pattern_sel,
    input  logic       region_start,
    input  logic       ram_ce,
    input  logic [7:0] ddr3_dout,
    output logic [7:0] din
);

    logic [8:0] offset;

    always_ff @(posedge clk) begin
        if (!rst_n || region_start) begin
            offset <= '0;
        end else if (ram_ce) begin
            offset <= offset + 1'b1;
        end
    end

    always_comb begin
        case (pattern_sel)
            3'd0:    din = ddr3_dout;
            3'd1:    din = 8'hFF;
            3'd2:    din = 8'h00;
            3'd3:    din = (offset[8] == offset[1]) ? 8'hFF : 8'h00;  // Pairs, flip at 256
            3'd4:    din = (offset[8] != offset[0]) ? 8'hFF : 8'h00;
            3'd5:    din = offset[7] ? 8'hFF : 8'h00;
            default: din = 8'hFF;
        endcase
    end

endmodule

// ==== verilog/load_sequencer.sv ====
//########################################
// Load FSM. Clears the slot table, walks
// the image records in DDR, fills RAM and
// issues block stores and lookup entries.
//########################################
`include "loader_params.svh"

module load_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_start,
    input  load_pkg::img_size_t    img_size,
    input  logic [7:0]             ddr3_dout,
    input  logic                   ddr3_ready,
    input  logic                   sdram_ready,
    output load_pkg::ddr_addr_t    ddr3_addr,
    output logic                   ddr3_rd,
    output logic                   ddr3_request,
    output logic                   reset_rq,
    output logic                   load_done,
    output logic                   ram_ce,
    output load_pkg::ram_addr_t    ram_addr,
    output logic [2:0]             pattern_sel,
    output logic                   region_start,
    output logic                   table_clear,
    output logic [5:0]             clear_index,
    output load_pkg::block_store_t block_store,
    output msx_pkg::ram_lookup_t   ram_lookup [`LD_RAM_REFS],
    output msx_pkg::bios_config_t  bios_config
);
    import msx_pkg::*;
    import load_pkg::*;

    ld_state_t   state;
    logic [7:0]  rec [`LD_REC_BYTES];
    logic [3:0]  rec_idx;
    ram_ref_t    ref_ram;
    logic        ref_add;          // Region allocated for this record
    ram_addr_t   fill_left;
    logic        advance;
    logic        sig_ok;
    rec_type_t   rec_type;
    data_id_t    data_id;
    mem_device_t device;
    logic [15:0] size_units;

    assign advance      = ddr3_ready && !ddr3_rd;
    assign reset_rq     = state != ST_IDLE;
    assign ddr3_request = reset_rq;
    assign table_clear  = state == ST_CLEAN && advance;
    assign sig_ok       = rec[0] == `LD_SIG0 && rec[1] == `LD_SIG1 && rec[2] == `LD_SIG2;
    assign rec_type     = rec_type_t'(rec[`LD_REC_TYPE][7:4]);
    assign data_id      = data_id_t'(rec[`LD_REC_ID]);
    assign device       = mem_device_t'(rec[`LD_REC_ID]);
    assign size_units   = {rec[`LD_REC_SIZE_HI], rec[`LD_REC_SIZE_LO]};
    assign pattern_sel  = (data_id == DATA_RAM) ? rec[`LD_REC_PATTERN][2:0] : 3'd0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            ddr3_rd         <= 1'b0;
            ram_ce          <= 1'b0;
            load_done       <= 1'b0;
            region_start    <= 1'b0;
            block_store.stb <= 1'b0;
        end else begin
            ram_ce          <= 1'b0;
            load_done       <= 1'b0;
            region_start    <= 1'b0;
            block_store.stb <= 1'b0;

            if (ram_ce) ram_addr <= ram_addr + 1'b1;
            if (ddr3_ready && ddr3_rd) begin
                ddr3_rd   <= 1'b0;
                ddr3_addr <= ddr3_addr + 1'b1;
            end

            if (load_start) begin
                state       <= ST_CLEAN;
                ddr3_rd     <= 1'b0;
                ddr3_addr   <= '0;
                ram_addr    <= '0;
                clear_index <= '0;
                rec_idx     <= '0;
                ref_ram     <= '0;
                ref_add     <= 1'b0;
                bios_config <= '0;
            end else if (advance) begin
                case (state)
                    ST_CLEAN: begin
                        if (clear_index < 6'(`LD_RAM_REFS)) ram_lookup[clear_index[3:0]] <= '0;
                        clear_index <= clear_index + 1'b1;
                        if (clear_index == 6'(`LD_SLOT_BLOCKS - 1)) state <= ST_READ_REC;
                    end

                    ST_READ_REC: begin
                        if (ddr3_addr >= ddr_addr_t'(img_size)) begin
                            state     <= ST_IDLE;      // End of image
                            load_done <= 1'b1;
                        end else begin
                            ddr3_rd <= 1'b1;
                            state   <= ST_READ_BYTE;
                        end
                    end

                    ST_READ_BYTE: begin
                        rec[rec_idx] <= ddr3_dout;
                        rec_idx      <= rec_idx + 1'b1;
                        if (rec_idx == 4'(`LD_REC_BYTES - 1)) state <= ST_CHECK;
                        else ddr3_rd <= 1'b1;
                    end

                    ST_CHECK: begin
                        state <= ST_READ_REC;
                        if (!sig_ok) begin
                            state     <= ST_IDLE;
                            load_done <= 1'b1;
                        end else if (rec_type == REC_SLOT_INTERNAL) begin
                            state <= ST_FILL;
                            if (device == DEVICE_FDC) bios_config.use_fdc <= 1'b1;
                            if (data_id == DATA_RAM &&
                                rec[`LD_REC_SIZE_LO] > bios_config.ram_size) begin
                                bios_config.ram_size <= rec[`LD_REC_SIZE_LO];
                            end
                        end else if (rec_type == REC_CONFIG) begin
                            bios_config.slot_expander_en <= rec[`LD_REC_ID][3:0];
                            bios_config.msx_typ          <= msx_typ_t'(rec[`LD_REC_ID][5:4]);
                        end
                    end

                    ST_FILL: begin
                        state <= ST_STORE;
                        if (size_units != 16'd0) begin
                            ram_lookup[ref_ram].addr <= ram_addr;
                            ram_lookup[ref_ram].size <= size_units;
                            ram_lookup[ref_ram].ro   <= data_id != DATA_RAM;
                            fill_left    <= ram_addr_t'(size_units) << `LD_BLOCK_SHIFT;
                            ref_add      <= 1'b1;
                            region_start <= 1'b1;
                            state        <= ST_FILL2;
                            if (data_id != DATA_RAM) ddr3_rd <= 1'b1;   // Prefetch
                        end
                    end

                    ST_FILL2: begin
                        if (sdram_ready && !ram_ce) begin
                            ram_ce    <= 1'b1;
                            fill_left <= fill_left - 1'b1;
                            if (fill_left == ram_addr_t'(1)) state <= ST_STORE;
                            else if (data_id != DATA_RAM) ddr3_rd <= 1'b1;
                        end
                    end

                    ST_STORE: begin
                        block_store.slot_sel <= rec[`LD_REC_TYPE][3:0];
                        block_store.mode     <= rec[`LD_REC_MODE];
                        block_store.param    <= rec[`LD_REC_PARAM];
                        block_store.mapper   <= mapper_t'(rec[`LD_REC_MAPPER]);
                        block_store.device   <= device;
                        block_store.ref_ram  <= ref_ram;
                        block_store.data_id  <= data_id;
                        block_store.stb      <= 1'b1;
                        ref_ram <= ref_ram + ram_ref_t'(ref_add);
                        ref_add <= 1'b0;
                        state   <= ST_READ_REC;
                    end

                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== verilog/upload_tracker.sv ====
//########################################
// Watches the host download. At the end of
// an image download it keeps the size and
// starts a load; reload restarts one.
//########################################
`include "loader_params.svh"

module upload_tracker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ioctl_download,
    input  logic [15:0]         ioctl_index,
    input  load_pkg::img_size_t ioctl_addr,
    input  logic                reload,
    output load_pkg::img_size_t img_size,
    output logic                load_start
);

    logic download_q;
    logic image_done;

    assign image_done = download_q && !ioctl_download &&
                        ioctl_index == 16'(`LD_IMG_INDEX);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            download_q <= 1'b0;
            load_start <= 1'b0;
        end else begin
            download_q <= ioctl_download;
            load_start <= image_done || reload;
        end
    end

    always_ff @(posedge clk) begin
        if (image_done) img_size <= ioctl_addr;   // Byte count of image
    end

endmodule

// ==== verilog/load_pkg.sv ====
//########################################
// Loader-side types: addresses, record
// and data ids, sequencer states and the
// RAM write and block store bundles.
//########################################
`include "loader_params.svh"

package load_pkg;

    typedef logic [`LD_DDR_AW-1:0] ddr_addr_t;
    typedef logic [`LD_RAM_AW-1:0] ram_addr_t;
    typedef logic [`LD_IMG_AW-1:0] img_size_t;
    typedef logic [3:0]            slot_sel_t;   // Slot [3:2], subslot [1:0]

    typedef enum logic [3:0] {
        REC_NONE,
        REC_FW,
        REC_SLOT_A,
        REC_SLOT_B,
        REC_SLOT_INTERNAL,
        REC_DEVICE,
        REC_CONFIG,
        REC_KBD_LAYOUT
    } rec_type_t;

    typedef enum logic [7:0] {
        DATA_NONE = 8'h00,
        DATA_ROM  = 8'h01,
        DATA_RAM  = 8'h02
    } data_id_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAN,
        ST_READ_REC,
        ST_READ_BYTE,
        ST_CHECK,
        ST_FILL,
        ST_FILL2,
        ST_STORE
    } ld_state_t;

    typedef struct packed {
        ram_addr_t  addr;
        logic [7:0] din;
        logic       ce;
    } ram_wr_t;

    typedef struct packed {
        slot_sel_t            slot_sel;
        logic [7:0]           mode;      // Four 2-bit fields, block 0 in [1:0]
        logic [7:0]           param;
        msx_pkg::mapper_t     mapper;
        msx_pkg::mem_device_t device;
        msx_pkg::ram_ref_t    ref_ram;
        data_id_t             data_id;
        logic                 stb;
    } block_store_t;

endpackage

// ==== verilog/msx_pkg.sv ====
//########################################
// Machine-side types: slot layout blocks,
// RAM lookup entries and BIOS config.
// Shared by the loader and the MSX core.
//########################################
`include "loader_params.svh"

package msx_pkg;

    typedef enum logic [7:0] {
        MAPPER_NONE       = 8'h00,
        MAPPER_ASCII8     = 8'h01,
        MAPPER_ASCII16    = 8'h02,
        MAPPER_KONAMI     = 8'h03,
        MAPPER_KONAMI_SCC = 8'h04,
        MAPPER_UNUSED     = 8'hFF      // Empty block
    } mapper_t;

    // Other device codes pass through from records unchanged
    typedef enum logic [7:0] {
        DEVICE_NONE = 8'h00,
        DEVICE_FDC  = 8'h03
    } mem_device_t;

    typedef enum logic [1:0] {
        MSX1,
        MSX2,
        MSX2P,
        MSXTR
    } msx_typ_t;

    typedef logic [3:0] ram_ref_t;

    typedef struct packed {
        mapper_t     mapper;
        mem_device_t device;
        ram_ref_t    ref_ram;
        logic [1:0]  offset_ram;       // 16 KB page within region
        logic        external;
    } slot_block_t;

    typedef struct packed {
        logic [`LD_RAM_AW-1:0] addr;
        logic [15:0]           size;   // In 16 KB units
        logic                  ro;
    } ram_lookup_t;

    typedef struct packed {
        logic [7:0] ram_size;
        logic       use_fdc;
        logic [3:0] slot_expander_en;
        msx_typ_t   msx_typ;
    } bios_config_t;

endpackage

// ==== verilog/loader_params.svh ====
//########################################
// Loader constants: table sizes, address
// widths, record layout and signature.
// Include where a width or offset is used.
//########################################
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

`define LD_SLOT_BLOCKS  64
`define LD_RAM_REFS     16
`define LD_REC_BYTES    16
`define LD_BLOCK_SHIFT  14      // 16 KB size unit
`define LD_IMG_INDEX    1       // Download index of the machine image

`define LD_SIG0         8'h4D   // 'M'
`define LD_SIG1         8'h53   // 'S'
`define LD_SIG2         8'h58   // 'X'

`define LD_REC_TYPE     3       // Type in [7:4], slot/subslot in [3:0]
`define LD_REC_ID       4
`define LD_REC_SIZE_HI  5
`define LD_REC_SIZE_LO  6
`define LD_REC_MAPPER   8
`define LD_REC_MODE     9
`define LD_REC_PARAM    10
`define LD_REC_PATTERN  11

`define LD_DDR_AW       28
`define LD_RAM_AW       27
`define LD_IMG_AW       27

`endif
